// File: Makefile
# Verilator build and run of the camera pixel path testbench
TOP := camera_pipeline_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir

// File: bench/camera_pipeline_tb.sv
// Camera pixel path testbench with a Bayer frame generator and a reference word queue
`timescale 1ns/10ps

module camera_pipeline_tb;
  import camera_pkg::*;

  localparam int frame_w = 8;  // in_width for every frame
  localparam int frame_h = 6;

  logic                         ccd_pixel_clk;
  logic                         rst;
  logic [raw_width-1:0]         ccd_data;
  logic                         ccd_fval;
  logic                         ccd_lval;
  logic                         start;
  logic                         hue_mode;
  logic [coord_width-1:0]       in_width;
  logic [out_width-1:0]         out_word;
  logic                         out_valid;
  logic [frame_count_width-1:0] frame_count;

  logic [raw_width-1:0] px [$];     // Current frame, row major
  logic [out_width-1:0] exp_q [$];  // Words still owed by the DUT
  logic [out_width-1:0] exp_word;
  int                   exp_frames; // Frames the capture rule admits

  camera_pipeline_top UUT (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .ccd_data      (ccd_data),
    .ccd_fval      (ccd_fval),
    .ccd_lval      (ccd_lval),
    .start         (start),
    .hue_mode      (hue_mode),
    .in_width      (in_width),
    .out_word      (out_word),
    .out_valid     (out_valid),
    .frame_count   (frame_count)
  );

  initial ccd_pixel_clk = 1'b0;
  always #2 ccd_pixel_clk = ~ccd_pixel_clk;  // 4 ns period

  // ====================
  // Failure reporting
  // ====================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] expected);
    abort_run($sformatf("error at %0d ns: %s is 0x%0h, expected 0x%0h",
                        $time, sig, got, expected));
  endtask

  // ====================
  // Reference model
  // ====================
  function automatic logic [hue_width-1:0] hue_of(input int r, input int g, input int b);
    int mx;
    int mn;
    int h;
    mx = (r > g) ? r : g;
    mx = (mx > b) ? mx : b;
    mn = (r < g) ? r : g;
    mn = (mn < b) ? mn : b;
    if (mx == mn) begin
      h = 0;                                                        // Gray
    end else if (r == mx) begin
      h = hue_sector_span * (g - b) / (mx - mn);                    // Red wins ties
    end else if (g == mx) begin
      h = hue_green_offset + hue_sector_span * (b - r) / (mx - mn);
    end else begin
      h = hue_blue_offset + hue_sector_span * (r - g) / (mx - mn);
    end
    return h[hue_width-1:0];  // Low byte, modulo 256
  endfunction

  // One pixel per quad, row pair by row pair
  task automatic push_expected();
    int i;
    int j;
    int g_sum;
    logic [raw_width-1:0] red;
    logic [raw_width-1:0] green;
    logic [raw_width-1:0] blue;
    for (i = 0; i < frame_h / 2; i++) begin
      for (j = 0; j < frame_w / 2; j++) begin
        red   = px[2 * i * frame_w + 2 * j + 1];        // Upper right
        blue  = px[(2 * i + 1) * frame_w + 2 * j];      // Lower left
        g_sum = int'(px[2 * i * frame_w + 2 * j]) + int'(px[(2 * i + 1) * frame_w + 2 * j + 1]);
        green = raw_width'(g_sum / 2);
        if (hue_mode) begin
          exp_q.push_back({8'h00, hue_of(int'(red[11:4]), int'(green[11:4]),
                                         int'(blue[11:4]))});
        end else begin
          exp_q.push_back({1'b0, red[11:7], green[11:7], blue[11:7]});  // RGB555
        end
      end
    end
  endtask

  // ====================
  // Frame generation
  // ====================
  function automatic logic [raw_width-1:0] nib();
    return raw_width'($urandom_range(15));
  endfunction

  // Writes one quad so both greens equal g
  task automatic set_quad(input int q, input logic [raw_width-1:0] r,
                          input logic [raw_width-1:0] g, input logic [raw_width-1:0] b);
    int base;
    base = (q / (frame_w / 2)) * 2 * frame_w + (q % (frame_w / 2)) * 2;
    px[base]               = g;
    px[base + 1]           = r;
    px[base + frame_w]     = b;
    px[base + frame_w + 1] = g;
  endtask

  task automatic build_frame(input bit forced);
    int n;
    int q;
    px.delete();
    for (n = 0; n < frame_h * frame_w; n++) begin
      px.push_back(raw_width'($urandom));
    end
    if (forced) begin
      for (q = 0; q < frame_h * frame_w / 4; q++) begin
        case (q % 7)
          1: set_quad(q, 12'h550 | nib(), 12'h550 | nib(), 12'h550 | nib());  // Gray
          2: set_quad(q, 12'hE00 | nib(), 12'h200 | nib(), 12'h900 | nib());  // Red, g<b
          3: set_quad(q, 12'h800 | nib(), 12'hF00 | nib(), 12'h100 | nib());  // Green, b<r
          4: set_quad(q, 12'h100 | nib(), 12'h700 | nib(), 12'hC00 | nib());  // Blue, r<g
          5: set_quad(q, 12'hA00 | nib(), 12'hA00 | nib(), 12'h300 | nib());  // Red/green tie
          6: set_quad(q, 12'h300 | nib(), 12'hB00 | nib(), 12'hB00 | nib());  // Green/blue tie
          default: ;  // Keep random quad
        endcase
      end
    end
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(posedge ccd_pixel_clk);
      n++;
    end
    assert (exp_q.size() == 0)
      else abort_run($sformatf("timeout: %0d expected words never came out", exp_q.size()));
  endtask

  task automatic close_frame();
    wait_drain(200);
    repeat (8) @(posedge ccd_pixel_clk);  // Stray words would pop an empty queue here
    assert (frame_count === frame_count_width'(exp_frames))
      else report_mismatch("frame_count", frame_count, 32'(exp_frames));
  endtask

  // Row index -1 means no start change or reset in this frame
  task automatic drive_frame(input bit capture, input bit forced, input int start_row,
                             input bit start_val, input int reset_row);
    int y;
    int x;
    int gap;
    capture_state_t seen_state;
    build_frame(forced);
    @(posedge ccd_pixel_clk);
    if (capture) begin
      push_expected();  // Mode already settled from the previous edge
      exp_frames++;
    end
    ccd_fval <= 1'b1;
    for (y = 0; y < frame_h; y++) begin
      if (y == start_row) begin
        start <= start_val;  // Mid-frame change
      end
      if (y == reset_row) begin
        rst   <= 1'b1;
        start <= 1'b0;       // Stay idle over the rest of this frame
        repeat (3) @(posedge ccd_pixel_clk);
        exp_q.delete();
        exp_frames = 0;
        rst <= 1'b0;
        seen_state = UUT.u_capture.state;
        assert (seen_state == idle)
          else abort_run($sformatf("capture state %s after reset, expected idle",
                                   seen_state.name()));
      end
      gap = 1 + $urandom_range(3);
      repeat (gap) begin
        @(posedge ccd_pixel_clk);
        ccd_lval <= 1'b0;
      end
      for (x = 0; x < frame_w; x++) begin
        @(posedge ccd_pixel_clk);
        ccd_lval <= 1'b1;
        ccd_data <= px[y * frame_w + x];
      end
    end
    gap = 1 + $urandom_range(2);
    repeat (gap) begin
      @(posedge ccd_pixel_clk);
      ccd_lval <= 1'b0;
    end
    ccd_fval <= 1'b0;
    repeat (2 + $urandom_range(4)) @(posedge ccd_pixel_clk);  // Frame gap
    close_frame();
  endtask

  task automatic set_start(input bit v);
    @(posedge ccd_pixel_clk);
    start <= v;
  endtask

  task automatic set_hue_mode(input bit v);
    @(posedge ccd_pixel_clk);
    hue_mode <= v;  // Only between frames
  endtask

  // ====================
  // Output checker
  // ====================
  always @(posedge ccd_pixel_clk) begin
    if (!rst && out_valid) begin
      assert (exp_q.size() != 0) else abort_run("out_valid rose with no word expected");
      if (exp_q.size() != 0) begin
        exp_word = exp_q.pop_front();
        assert (out_word === exp_word)
          else report_mismatch("out_word", 32'(out_word), 32'(exp_word));
      end
    end
  end

  initial begin
    void'($urandom(32'h9812dbf5));
    rst        = 1'b1;
    ccd_data   = '0;
    ccd_fval   = 1'b0;
    ccd_lval   = 1'b0;
    start      = 1'b0;
    hue_mode   = 1'b0;
    in_width   = coord_width'(frame_w);
    exp_frames = 0;
    repeat (3) @(posedge ccd_pixel_clk);
    rst <= 1'b0;
    @(posedge ccd_pixel_clk);
    assert (out_valid === 1'b0) else report_mismatch("out_valid", 32'(out_valid), 32'h0);
    assert (frame_count === '0) else report_mismatch("frame_count", frame_count, 32'h0);

    drive_frame(1'b0, 1'b0, -1, 1'b0, -1);  // Start low, nothing captured
    drive_frame(1'b0, 1'b0, -1, 1'b0, -1);
    set_start(1'b1);
    drive_frame(1'b1, 1'b0, -1, 1'b0, -1);  // RGB mode
    drive_frame(1'b1, 1'b0, -1, 1'b0, -1);
    set_hue_mode(1'b1);
    drive_frame(1'b1, 1'b1, -1, 1'b0, -1);  // Forced hue corners
    drive_frame(1'b1, 1'b1, -1, 1'b0, -1);
    drive_frame(1'b1, 1'b0, -1, 1'b0, -1);
    drive_frame(1'b1, 1'b1, 2, 1'b0, -1);   // Start dropped, frame still whole
    set_hue_mode(1'b0);
    drive_frame(1'b0, 1'b0, 2, 1'b1, -1);   // Start raised late, frame skipped
    drive_frame(1'b1, 1'b0, -1, 1'b0, -1);
    drive_frame(1'b1, 1'b0, -1, 1'b0, 3);   // Reset inside the frame
    set_start(1'b1);
    drive_frame(1'b1, 1'b0, -1, 1'b0, -1);  // Capture resumes

    if (exp_q.size() != 0) begin
      abort_run("expected words left over at the end of the run");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// File: flist.f
verilog/camera_pkg.sv
verilog/ccd_sample_if.sv
verilog/rgb_pixel_if.sv
verilog/ccd_capture.sv
verilog/bayer_demosaic.sv
verilog/rgb_to_hue.sv
verilog/camera_pipeline_top.sv
bench/camera_pipeline_tb.sv

// File: verilog/bayer_demosaic.sv
// Bayer demosaic combining each 2x2 quad into one RGB pixel through a one-row line buffer
`timescale 1ns/10ps

module bayer_demosaic (
  input  logic         ccd_pixel_clk,
  input  logic         rst,
  ccd_sample_if.sink   samples,
  rgb_pixel_if.source  pixels
);
  import camera_pkg::*;

  // Even-row store, indexed by column
  logic [raw_width-1:0]       line_buf [max_line_width];
  logic [raw_width-1:0]       prev_sample;   // Left neighbour, current row
  logic [line_addr_width-1:0] wr_addr;
  logic [line_addr_width-1:0] left_addr;
  logic [raw_width-1:0]       upper_left;
  logic [raw_width-1:0]       upper_right;
  logic [raw_width:0]         green_sum;     // One extra bit for the add
  logic                       quad_done;

  // ====================
  // Quad addressing
  // ====================
  assign wr_addr   = samples.x[line_addr_width-1:0];
  assign left_addr = {wr_addr[line_addr_width-1:1], 1'b0};  // Even column of the quad

  assign upper_left  = line_buf[left_addr];  // Green, even row even col
  assign upper_right = line_buf[wr_addr];    // Red, even row odd col
  assign green_sum   = {1'b0, upper_left} + {1'b0, samples.data};

  // Odd row, odd column closes a quad
  assign quad_done = samples.valid & samples.x[0] & samples.y[0];

  // Even rows only
  always_ff @(posedge ccd_pixel_clk) begin
    if (samples.valid && !samples.y[0]) begin
      line_buf[wr_addr] <= samples.data;
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (samples.valid) begin
      prev_sample <= samples.data;  // Blue when the odd column arrives
    end
  end

  // ====================
  // Pixel output
  // ====================
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      pixels.valid <= 1'b0;
    end else begin
      pixels.valid <= quad_done;
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (quad_done) begin
      pixels.red   <= upper_right;
      pixels.green <= green_sum[raw_width:1];  // Halved, truncated
      pixels.blue  <= prev_sample;
    end
  end

  // At most one pixel per column pair, so strobes are never back to back
  a_pixel_gap: assert property (@(posedge ccd_pixel_clk) disable iff (rst)
    pixels.valid |=> !pixels.valid);

endmodule

// File: verilog/camera_pipeline_top.sv
// Camera pixel path top with capture, demosaic, hue and the output word formatter
`timescale 1ns/10ps

module camera_pipeline_top (
  input  logic                                     ccd_pixel_clk,
  input  logic                                     rst,
  input  logic [camera_pkg::raw_width-1:0]         ccd_data,
  input  logic                                     ccd_fval,
  input  logic                                     ccd_lval,
  input  logic                                     start,
  input  logic                                     hue_mode,   // 1 selects hue words
  input  logic [camera_pkg::coord_width-1:0]       in_width,
  output logic [camera_pkg::out_width-1:0]         out_word,
  output logic                                     out_valid,
  output logic [camera_pkg::frame_count_width-1:0] frame_count
);
  import camera_pkg::*;

  ccd_sample_if sample_bus ();
  rgb_pixel_if  pixel_bus ();  // Shared by hue stage and formatter

  logic                 hue_valid;
  logic [hue_width-1:0] hue;
  logic [out_width-1:0] rgb_word;
  logic [out_width-1:0] hue_word;

  // ====================
  // Pixel path
  // ====================
  ccd_capture u_capture (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .ccd_data      (ccd_data),
    .ccd_fval      (ccd_fval),
    .ccd_lval      (ccd_lval),
    .start         (start),
    .in_width      (in_width),
    .samples       (sample_bus.source),
    .frame_count   (frame_count)
  );

  bayer_demosaic u_demosaic (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .samples       (sample_bus.sink),
    .pixels        (pixel_bus.source)
  );

  rgb_to_hue u_hue (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .pixels        (pixel_bus.sink),
    .hue_valid     (hue_valid),
    .hue           (hue)
  );

  // ====================
  // Output formatter
  // ====================
  // Zero bit then 5:5:5 from the top of each colour
  assign rgb_word = {{(out_width - 3 * rgb555_bits){1'b0}},
                     pixel_bus.red[raw_width-1 -: rgb555_bits],
                     pixel_bus.green[raw_width-1 -: rgb555_bits],
                     pixel_bus.blue[raw_width-1 -: rgb555_bits]};
  assign hue_word = {{(out_width - hue_width){1'b0}}, hue};  // Hue in low byte

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= hue_mode ? hue_valid : pixel_bus.valid;
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    out_word <= hue_mode ? hue_word : rgb_word;
  end

endmodule

// File: verilog/camera_pkg.sv
// Camera pixel path package with widths, buffer depth, hue constants and state types
package camera_pkg;

  // ====================
  // Data path widths
  // ====================
  localparam int raw_width         = 12;    // Bayer sample bits
  localparam int coord_width       = 12;    // Column and row counters, in_width
  localparam int max_line_width    = 1280;  // Widest line the buffer holds
  localparam int line_addr_width   = $clog2(max_line_width);
  localparam int hue_width         = 8;     // Component bits into hue, hue bits
  localparam int out_width         = 16;    // Formatted output word
  localparam int rgb555_bits       = 5;     // Kept bits per colour in RGB mode
  localparam int frame_count_width = 32;

  // ====================
  // Hue constants
  // ====================
  // One sixth of the 256-step wheel
  localparam int hue_sector_span  = 43;
  localparam int hue_green_offset = 85;     // Start of green third
  localparam int hue_blue_offset  = 171;    // Start of blue third
  localparam int hue_num_width    = 16;     // Signed span * diff, 43 * 255 max

  // Capture controller states
  typedef enum logic [1:0] {
    idle,        // Not armed
    wait_frame,  // Armed, waiting for a frame start
    capturing    // Inside an admitted frame
  } capture_state_t;

  // Which component is largest
  typedef enum logic [1:0] {
    sector_gray,
    sector_red,
    sector_green,
    sector_blue
  } hue_sector_t;

endpackage

// File: verilog/ccd_capture.sv
// Sensor pin registers and whole-frame capture control with pixel and frame counters
`timescale 1ns/10ps

module ccd_capture (
  input  logic                                     ccd_pixel_clk,
  input  logic                                     rst,
  input  logic [camera_pkg::raw_width-1:0]         ccd_data,
  input  logic                                     ccd_fval,
  input  logic                                     ccd_lval,
  input  logic                                     start,
  input  logic [camera_pkg::coord_width-1:0]       in_width,
  ccd_sample_if.source                             samples,
  output logic [camera_pkg::frame_count_width-1:0] frame_count
);
  import camera_pkg::*;

  logic [raw_width-1:0]   data_q;
  logic [raw_width-1:0]   data_q2;
  logic                   fval_q;
  logic                   fval_q2;
  logic                   lval_q;
  logic                   lval_q2;
  capture_state_t         state;
  logic [coord_width-1:0] x_cnt;
  logic [coord_width-1:0] y_cnt;
  logic                   frame_rise;
  logic                   frame_fall;
  logic                   sample_hit;
  logic                   line_end;

  // ====================
  // Pin registers
  // ====================
  always_ff @(posedge ccd_pixel_clk) begin
    data_q  <= ccd_data;  // Stage one at the pins
    data_q2 <= data_q;    // Aligned with the edge detect
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      fval_q  <= 1'b0;
      fval_q2 <= 1'b0;
      lval_q  <= 1'b0;
      lval_q2 <= 1'b0;
    end else begin
      fval_q  <= ccd_fval;
      fval_q2 <= fval_q;
      lval_q  <= ccd_lval;
      lval_q2 <= lval_q;
    end
  end

  assign frame_rise = fval_q & ~fval_q2;
  assign frame_fall = ~fval_q & fval_q2;
  assign sample_hit = (state == capturing) & fval_q2 & lval_q2;
  assign line_end   = (x_cnt == in_width - 1'b1);  // Last column of the line

  // ====================
  // Frame controller
  // ====================
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      state       <= idle;
      frame_count <= '0;
    end else begin
      case (state)
        idle: begin
          if (start) begin
            state <= wait_frame;
          end
        end
        wait_frame: begin
          // Only a fresh frame start is admitted
          if (frame_rise) begin
            state       <= capturing;
            frame_count <= frame_count + 1'b1;
          end
        end
        capturing: begin
          if (frame_fall) begin
            state <= start ? wait_frame : idle;  // Frame always finishes
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Column and row counters
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst || frame_rise) begin
      x_cnt <= '0;
      y_cnt <= '0;
    end else if (sample_hit) begin
      if (line_end) begin
        x_cnt <= '0;
        y_cnt <= y_cnt + 1'b1;
      end else begin
        x_cnt <= x_cnt + 1'b1;
      end
    end
  end

  // Sample strobe out
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      samples.valid <= 1'b0;
    end else begin
      samples.valid <= sample_hit;
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    samples.data <= data_q2;
    samples.x    <= x_cnt;
    samples.y    <= y_cnt;
  end

  // Every captured sample needs a width the demosaic buffer can hold in whole quads
  a_width_legal: assert property (@(posedge ccd_pixel_clk) disable iff (rst)
    sample_hit |-> (in_width != '0) && !in_width[0] && (in_width <= max_line_width));

endmodule

// File: verilog/ccd_sample_if.sv
// Captured Bayer sample stream with column and row coordinates
`timescale 1ns/10ps

interface ccd_sample_if;
  import camera_pkg::*;

  logic                   valid;  // One-cycle strobe per sample
  logic [raw_width-1:0]   data;   // Raw Bayer value
  logic [coord_width-1:0] x;      // Column within the line
  logic [coord_width-1:0] y;      // Row within the frame

  // Capture drives, demosaic listens
  modport source (output valid, data, x, y);
  modport sink   (input  valid, data, x, y);

endinterface

// File: verilog/rgb_pixel_if.sv
// Demosaiced 12-bit RGB pixel stream
`timescale 1ns/10ps

interface rgb_pixel_if;
  import camera_pkg::*;

  logic                 valid;  // Strobe, one per Bayer quad
  logic [raw_width-1:0] red;
  logic [raw_width-1:0] green;  // Mean of the two greens
  logic [raw_width-1:0] blue;

  // One source, hue stage and formatter both sink
  modport source (output valid, red, green, blue);
  modport sink   (input  valid, red, green, blue);

endinterface

// File: verilog/rgb_to_hue.sv
// Three-stage hue pipeline over the upper 8 bits of each colour component
`timescale 1ns/10ps

module rgb_to_hue (
  input  logic                             ccd_pixel_clk,
  input  logic                             rst,
  rgb_pixel_if.sink                        pixels,
  output logic                             hue_valid,
  output logic [camera_pkg::hue_width-1:0] hue
);
  import camera_pkg::*;

  logic [hue_width-1:0]            r;
  logic [hue_width-1:0]            g;
  logic [hue_width-1:0]            b;
  logic [hue_width-1:0]            max_c;
  logic [hue_width-1:0]            min_c;
  logic signed [hue_width:0]       diff_c;     // Sector numerator before scaling
  hue_sector_t                     sector_c;
  logic                            valid1;
  logic                            valid2;
  hue_sector_t                     sector1;
  hue_sector_t                     sector2;
  logic [hue_width-1:0]            delta1;
  logic signed [hue_num_width-1:0] num1;
  logic signed [hue_num_width-1:0] divisor;
  logic signed [hue_num_width-1:0] quot_full;
  logic [hue_width-1:0]            quot2;
  logic [hue_width-1:0]            offset_c;

  assign r = pixels.red[raw_width-1 -: hue_width];
  assign g = pixels.green[raw_width-1 -: hue_width];
  assign b = pixels.blue[raw_width-1 -: hue_width];

  // ====================
  // Stage one
  // ====================
  always_comb begin
    // Ties favour red, then green
    if (r >= g && r >= b) begin
      sector_c = sector_red;
      max_c    = r;
      diff_c   = $signed({1'b0, g}) - $signed({1'b0, b});
    end else if (g >= b) begin
      sector_c = sector_green;
      max_c    = g;
      diff_c   = $signed({1'b0, b}) - $signed({1'b0, r});
    end else begin
      sector_c = sector_blue;
      max_c    = b;
      diff_c   = $signed({1'b0, r}) - $signed({1'b0, g});
    end
    min_c = (r <= g) ? ((r <= b) ? r : b) : ((g <= b) ? g : b);
    if (max_c == min_c) begin
      sector_c = sector_gray;  // No chroma
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      valid1    <= 1'b0;
      valid2    <= 1'b0;
      hue_valid <= 1'b0;
    end else begin
      valid1    <= pixels.valid;
      valid2    <= valid1;
      hue_valid <= valid2;
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    sector1 <= sector_c;
    delta1  <= max_c - min_c;
    num1    <= (sector_c == sector_gray) ? '0 :
               hue_num_width'(diff_c * hue_sector_span);  // May be negative
  end

  // ====================
  // Stage two
  // ====================
  // Gray pixels carry delta 0, keep the divide defined
  assign divisor   = (delta1 == '0) ? hue_num_width'(1) : hue_num_width'(delta1);
  assign quot_full = num1 / divisor;  // Signed, truncates toward zero

  always_ff @(posedge ccd_pixel_clk) begin
    sector2 <= sector1;
    quot2   <= quot_full[hue_width-1:0];  // |quot| <= span fits
  end

  // ====================
  // Stage three
  // ====================
  always_comb begin
    case (sector2)
      sector_green: offset_c = hue_width'(hue_green_offset);
      sector_blue:  offset_c = hue_width'(hue_blue_offset);
      default:      offset_c = '0;  // Red and gray start at 0
    endcase
  end

  always_ff @(posedge ccd_pixel_clk) begin
    hue <= offset_c + quot2;  // Wraps modulo 256
  end

  // Fixed depth, no stalls, and the hue that lands belongs to that pixel
  a_hue_latency: assert property (@(posedge ccd_pixel_clk) disable iff (rst)
    pixels.valid |-> ##3 (hue_valid && ($past(r != g || g != b, 3) || (hue == '0))));

endmodule
